//--- Bender.yml
package:
  name: issue_stage

sources:
  - issue_pkg.sv
  - issue_slot_if.sv
  - issue_pc_tracker.sv
  - issue_block_fsm.sv
  - issue_scoreboard.sv
  - issue_regfile.sv
  - issue_select.sv
  - issue_top.sv
  - target: test
    files:
      - tb_issue_assert.sv
      - tb_issue.sv

//--- files.f
issue_pkg.sv
issue_slot_if.sv
issue_pc_tracker.sv
issue_block_fsm.sv
issue_scoreboard.sv
issue_regfile.sv
issue_select.sv
issue_top.sv
tb_issue_assert.sv
tb_issue.sv

//--- issue_block_fsm.sv
// Blocking state for divide and CSR operations
// Both run out of pipe with a variable latency, so nothing issues
// until the matching done strobe comes back
`timescale 1ns/1ns
`default_nettype none

module issue_block_fsm import issue_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    issue_slot_if.sink   slot_a,
    input  logic         issue_a_i,
    input  logic         div_done_i,
    input  logic         csr_done_i,
    output logic         block_o
);

    block_state_t state_q;
    block_state_t state_nxt;

    always_comb
    begin
        state_nxt = state_q;
        unique case (state_q)
            BLK_IDLE:
            begin
                // Only slot A may carry a divide or a CSR access
                if (issue_a_i && slot_a.cls == CLS_DIV)
                    state_nxt = BLK_DIV;
                else if (issue_a_i && slot_a.cls == CLS_CSR)
                    state_nxt = BLK_CSR;
            end
            BLK_DIV:
            begin
                if (div_done_i)
                    state_nxt = BLK_IDLE;
            end
            BLK_CSR:
            begin
                if (csr_done_i)
                    state_nxt = BLK_IDLE;
            end
            default:
            begin
                state_nxt = BLK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= BLK_IDLE;
        else
            state_q <= state_nxt;
    end

    // Still high in the done cycle, issue resumes one cycle later
    assign block_o = (state_q != BLK_IDLE);

endmodule

`default_nettype wire

//--- issue_pc_tracker.sv
// Expected PC tracker
// Holds the PC of the next instruction in program order and steps it
// by one or two words per issue, or loads a redirect target
`timescale 1ns/1ns
`default_nettype none

module issue_pc_tracker import issue_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic            single_i,
    input  logic            dual_i,
    output logic [XLEN-1:0] expected_pc_o
);

    localparam logic [XLEN-1:0] STEP_ONE = XLEN'(INSTR_BYTES);
    localparam logic [XLEN-1:0] STEP_TWO = XLEN'(2 * INSTR_BYTES);

    logic [XLEN-1:0] pc_q;

    // Redirect wins over any issue in the same cycle
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            pc_q <= PC_RESET;
        end
        else if (redirect_i)
        begin
            pc_q <= redirect_pc_i;
        end
        else if (dual_i)
        begin
            pc_q <= pc_q + STEP_TWO;
        end
        else if (single_i)
        begin
            pc_q <= pc_q + STEP_ONE;
        end
    end

    assign expected_pc_o = pc_q;

endmodule

`default_nettype wire

//--- issue_pkg.sv
// Issue stage shared definitions
// Widths, instruction field positions and the class and state encodings
`default_nettype none

package issue_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    // Register index fields in the instruction word
    localparam int RD_LSB = 7;
    localparam int RA_LSB = 15;
    localparam int RB_LSB = 20;

    // --------------------
    // PC
    // --------------------
    localparam int INSTR_BYTES = 4;
    localparam logic [XLEN-1:0] PC_RESET = '0;

    // Coarse class from the fetch side decoder
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_MUL,
        CLS_DIV,
        CLS_CSR
    } op_class_t;

    // Issue blocked while a divide or CSR op is in flight
    typedef enum logic [1:0] {
        BLK_IDLE,
        BLK_DIV,
        BLK_CSR
    } block_state_t;

endpackage

`default_nettype wire

//--- issue_regfile.sv
// Integer register file
// 32 x 32, one write port from writeback, four combinational read
// ports with writeback bypass, x0 hardwired to zero
`timescale 1ns/1ns
`default_nettype none

module issue_regfile import issue_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wb_valid_i,
    input  logic [REG_IDX_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]      wb_value_i,
    issue_slot_if.sink           slot_a,
    issue_slot_if.sink           slot_b,
    output logic [XLEN-1:0]      a_ra_o,
    output logic [XLEN-1:0]      a_rb_o,
    output logic [XLEN-1:0]      b_ra_o,
    output logic [XLEN-1:0]      b_rb_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (wb_valid_i)
        begin
            regs_q[wb_rd_i] <= wb_value_i;
        end
    end

    // Newest value first: a write in flight this cycle beats the array
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_IDX_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0)
            val = '0;
        else if (wb_valid_i && (wb_rd_i == idx))
            val = wb_value_i;
        else
            val = regs_q[idx];
        return val;
    endfunction

    assign a_ra_o = read_reg(slot_a.ra_idx);
    assign a_rb_o = read_reg(slot_a.rb_idx);
    assign b_ra_o = read_reg(slot_b.ra_idx);
    assign b_rb_o = read_reg(slot_b.rb_idx);

endmodule

`default_nettype wire

//--- issue_scoreboard.sv
// Register scoreboard
// One pending bit per register for results that come back late
// (load, multiply, divide), plus hazard checks for both slots
`timescale 1ns/1ns
`default_nettype none

module issue_scoreboard import issue_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    issue_slot_if.sink           slot_a,
    issue_slot_if.sink           slot_b,
    input  logic                 issue_a_i,
    input  logic                 issue_b_i,
    input  logic                 wb_valid_i,
    input  logic [REG_IDX_W-1:0] wb_rd_i,
    output logic                 hazard_a_o,
    output logic                 hazard_b_o
);

    logic [NUM_REGS-1:0] pending_q;
    logic [NUM_REGS-1:0] wb_clr;
    logic [NUM_REGS-1:0] pending_eff;
    logic [NUM_REGS-1:0] pending_nxt;
    logic                b_dep_on_a;

    function automatic logic is_long_lat(input op_class_t cls);
        return (cls == CLS_LOAD) || (cls == CLS_MUL) || (cls == CLS_DIV);
    endfunction

    // Writeback releases its register in the same cycle
    always_comb
    begin
        wb_clr = '0;
        if (wb_valid_i)
            wb_clr[wb_rd_i] = 1'b1;
    end

    assign pending_eff = pending_q & ~wb_clr;

    always_comb
    begin
        pending_nxt = pending_eff;
        if (issue_a_i && is_long_lat(slot_a.cls) && (|slot_a.rd_idx))
            pending_nxt[slot_a.rd_idx] = 1'b1;
        if (issue_b_i && is_long_lat(slot_b.cls) && (|slot_b.rd_idx))
            pending_nxt[slot_b.rd_idx] = 1'b1;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pending_q <= '0;
        else
            pending_q <= pending_nxt;
    end

    // --------------------
    // Hazards
    // --------------------
    assign hazard_a_o = pending_eff[slot_a.ra_idx] |
                        pending_eff[slot_a.rb_idx] |
                        pending_eff[slot_a.rd_idx];

    // Slot B may not touch what slot A is about to write
    assign b_dep_on_a = slot_a.valid && (|slot_a.rd_idx) &&
                        ((slot_b.ra_idx == slot_a.rd_idx) ||
                         (slot_b.rb_idx == slot_a.rd_idx) ||
                         (slot_b.rd_idx == slot_a.rd_idx));

    assign hazard_b_o = pending_eff[slot_b.ra_idx] |
                        pending_eff[slot_b.rb_idx] |
                        pending_eff[slot_b.rd_idx] |
                        b_dep_on_a;

endmodule

`default_nettype wire

//--- issue_select.sv
// Issue slot selection
// Picks slot contents from the fetch pair, flags a mispredict when
// no word sits at the expected PC, applies the dual issue pairing
// rules and produces the fetch accepts
`timescale 1ns/1ns
`default_nettype none

module issue_select import issue_pkg::*;
(
    input  logic            fetch0_valid_i,
    input  logic [XLEN-1:0] fetch0_instr_i,
    input  logic [XLEN-1:0] fetch0_pc_i,
    input  op_class_t       fetch0_cls_i,
    input  logic            fetch1_valid_i,
    input  logic [XLEN-1:0] fetch1_instr_i,
    input  logic [XLEN-1:0] fetch1_pc_i,
    input  op_class_t       fetch1_cls_i,
    input  logic [XLEN-1:0] expected_pc_i,
    input  logic            redirect_i,
    input  logic            block_i,
    input  logic            hazard_a_i,
    input  logic            hazard_b_i,
    issue_slot_if.src       slot_a,
    issue_slot_if.src       slot_b,
    output logic            issue_a_o,
    output logic            issue_b_o,
    output logic            fetch0_accept_o,
    output logic            fetch1_accept_o,
    output logic            mispredict_o
);

    logic sel0;
    logic sel1;
    logic pair_ok;

    // --------------------
    // Slot selection
    // --------------------
    assign sel0 = !redirect_i && fetch0_valid_i && (fetch0_pc_i == expected_pc_i);
    assign sel1 = !redirect_i && !sel0 && fetch1_valid_i && (fetch1_pc_i == expected_pc_i);

    // Valid words but none where program order says: fetch went astray
    assign mispredict_o = !redirect_i && !sel0 && !sel1 && (fetch0_valid_i || fetch1_valid_i);

    always_comb
    begin
        slot_a.valid  = sel0 | sel1;
        slot_a.opcode = '0;
        slot_a.pc     = '0;
        slot_a.cls    = CLS_ALU;
        slot_b.valid  = sel0 & fetch1_valid_i;
        slot_b.opcode = '0;
        slot_b.pc     = '0;
        slot_b.cls    = CLS_ALU;

        if (sel0)
        begin
            slot_a.opcode = fetch0_instr_i;
            slot_a.pc     = fetch0_pc_i;
            slot_a.cls    = fetch0_cls_i;
            slot_b.opcode = fetch1_instr_i;
            slot_b.pc     = fetch1_pc_i;
            slot_b.cls    = fetch1_cls_i;
        end
        else if (sel1)
        begin
            // Word 1 moves to the primary slot and issues alone
            slot_a.opcode = fetch1_instr_i;
            slot_a.pc     = fetch1_pc_i;
            slot_a.cls    = fetch1_cls_i;
        end
    end

    assign slot_a.rd_idx = slot_a.opcode[RD_LSB +: REG_IDX_W];
    assign slot_a.ra_idx = slot_a.opcode[RA_LSB +: REG_IDX_W];
    assign slot_a.rb_idx = slot_a.opcode[RB_LSB +: REG_IDX_W];
    assign slot_b.rd_idx = slot_b.opcode[RD_LSB +: REG_IDX_W];
    assign slot_b.ra_idx = slot_b.opcode[RA_LSB +: REG_IDX_W];
    assign slot_b.rb_idx = slot_b.opcode[RB_LSB +: REG_IDX_W];

    // --------------------
    // Pairing rules
    // --------------------
    // Divide and CSR never pair, branches only in slot B
    always_comb
    begin
        pair_ok = 1'b0;
        if ((slot_a.cls inside {CLS_ALU, CLS_LOAD, CLS_STORE, CLS_MUL}) &&
            (slot_b.cls inside {CLS_ALU, CLS_BRANCH}))
            pair_ok = 1'b1;
        if ((slot_a.cls inside {CLS_ALU, CLS_MUL}) &&
            (slot_b.cls inside {CLS_LOAD, CLS_STORE}))
            pair_ok = 1'b1;
        if ((slot_a.cls inside {CLS_ALU, CLS_LOAD, CLS_STORE}) &&
            (slot_b.cls == CLS_MUL))
            pair_ok = 1'b1;
    end

    assign issue_a_o = slot_a.valid && !block_i && !hazard_a_i;
    assign issue_b_o = issue_a_o && slot_b.valid && !hazard_b_i && pair_ok;

    // Word 0 is dropped along with issuing word 1 when it sits off path
    assign fetch0_accept_o = (sel0 & issue_a_o) | (sel1 & issue_a_o);
    assign fetch1_accept_o = (sel1 & issue_a_o) | issue_b_o;

endmodule

`default_nettype wire

//--- issue_slot_if.sv
// One issue slot
// Decoded fields of the instruction that sits in the slot this cycle
`timescale 1ns/1ns
`default_nettype none

interface issue_slot_if import issue_pkg::*; ();

    logic                 valid;
    logic [XLEN-1:0]      opcode;
    logic [XLEN-1:0]      pc;
    op_class_t            cls;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [REG_IDX_W-1:0] ra_idx;
    logic [REG_IDX_W-1:0] rb_idx;

    // Slot select drives, the rest only look
    modport src (output valid, opcode, pc, cls, rd_idx, ra_idx, rb_idx);
    modport sink (input valid, opcode, pc, cls, rd_idx, ra_idx, rb_idx);

endinterface

`default_nettype wire

//--- issue_tests.txt
# in : name f0v f0_instr f0_pc f0_cls f1v f1_instr f1_pc f1_cls rdv rd_pc wbv wb_rd wb_val div csr
# exp: acc0 acc1 iv0 iv1 a_ra a_rb b_ra b_rb breq bpc (all hex, cls 0 alu 2 load 5 div 6 csr)
idle        0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
wb_r1       0 0 0 0 0 0 0 0 0 0 1 1 a1 0 0 0 0 0 0 0 0 0 0 0 0
wb_r2       0 0 0 0 0 0 0 0 0 0 1 2 b2 0 0 0 0 0 0 0 0 0 0 0 0
wb_r3       0 0 0 0 0 0 0 0 0 0 1 3 c3 0 0 0 0 0 0 0 0 0 0 0 0
alu_read    1 208200 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 a1 b2 0 0 0 0
alu_x0      1 300280 4 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 0 c3 0 0 0 4
alu_bypass  1 130380 8 0 0 0 0 0 0 0 1 6 f6 0 0 1 0 1 0 f6 a1 0 0 0 8
pair_alu    1 208400 c 0 1 618480 10 0 0 0 0 0 0 0 0 1 1 1 1 a1 b2 c3 f6 0 c
after_pair  1 310500 14 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 b2 c3 0 0 0 14
pair_div    1 208580 18 5 1 318600 1c 0 0 0 0 0 0 0 0 1 0 1 0 a1 b2 0 0 0 18
div_wait1   1 318600 1c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1c
div_wait2   1 318600 1c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1c
div_done    1 318600 1c 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1c
div_resume  1 318600 1c 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 c3 c3 0 0 0 1c
csr_issue   1 8680 20 6 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 a1 0 0 0 0 20
csr_wait    1 110700 24 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 24
csr_done    1 110700 24 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 24
csr_resume  1 110700 24 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 b2 a1 0 0 0 24
mispredict  1 208200 100 0 1 208200 104 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 28
load_issue  1 8780 28 2 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 a1 0 0 0 0 28
load_stall  1 278800 2c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2c
load_wb     1 278800 2c 0 0 0 0 0 0 0 1 f 5a5 0 0 1 0 1 0 5a5 b2 0 0 0 2c
redirect    1 310880 30 0 0 0 0 0 1 200 0 0 0 0 0 0 0 0 0 0 0 0 0 0 30
redir_fetch 1 310880 200 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 b2 c3 0 0 0 200

//--- issue_top.sv
// Two slot issue stage
// Fetch pair in, up to two instructions out with their operands,
// results return through a single writeback port
`timescale 1ns/1ns
`default_nettype none

module issue_top import issue_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        fetch0_valid_i,
    input  logic [XLEN-1:0]             fetch0_instr_i,
    input  logic [XLEN-1:0]             fetch0_pc_i,
    input  logic [$bits(op_class_t)-1:0] fetch0_cls_i,
    input  logic                        fetch1_valid_i,
    input  logic [XLEN-1:0]             fetch1_instr_i,
    input  logic [XLEN-1:0]             fetch1_pc_i,
    input  logic [$bits(op_class_t)-1:0] fetch1_cls_i,
    input  logic                        redirect_valid_i,
    input  logic [XLEN-1:0]             redirect_pc_i,
    input  logic                        wb_valid_i,
    input  logic [REG_IDX_W-1:0]        wb_rd_i,
    input  logic [XLEN-1:0]             wb_value_i,
    input  logic                        div_done_i,
    input  logic                        csr_done_i,
    output logic                        fetch0_accept_o,
    output logic                        fetch1_accept_o,
    output logic                        issue0_valid_o,
    output logic [XLEN-1:0]             issue0_opcode_o,
    output logic [XLEN-1:0]             issue0_pc_o,
    output logic [XLEN-1:0]             issue0_ra_value_o,
    output logic [XLEN-1:0]             issue0_rb_value_o,
    output logic                        issue1_valid_o,
    output logic [XLEN-1:0]             issue1_opcode_o,
    output logic [XLEN-1:0]             issue1_pc_o,
    output logic [XLEN-1:0]             issue1_ra_value_o,
    output logic [XLEN-1:0]             issue1_rb_value_o,
    output logic                        branch_request_o,
    output logic [XLEN-1:0]             branch_pc_o
);

    issue_slot_if slot_a ();
    issue_slot_if slot_b ();

    logic [XLEN-1:0] expected_pc;
    logic            issue_a;
    logic            issue_b;
    logic            block;
    logic            hazard_a;
    logic            hazard_b;
    logic            mispredict;

    // --------------------
    // Program order
    // --------------------
    issue_pc_tracker u_pc_tracker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .redirect_i    (redirect_valid_i),
        .redirect_pc_i (redirect_pc_i),
        .single_i      (issue_a & ~issue_b),
        .dual_i        (issue_b),
        .expected_pc_o (expected_pc)
    );

    issue_select u_select (
        .fetch0_valid_i  (fetch0_valid_i),
        .fetch0_instr_i  (fetch0_instr_i),
        .fetch0_pc_i     (fetch0_pc_i),
        .fetch0_cls_i    (op_class_t'(fetch0_cls_i)),
        .fetch1_valid_i  (fetch1_valid_i),
        .fetch1_instr_i  (fetch1_instr_i),
        .fetch1_pc_i     (fetch1_pc_i),
        .fetch1_cls_i    (op_class_t'(fetch1_cls_i)),
        .expected_pc_i   (expected_pc),
        .redirect_i      (redirect_valid_i),
        .block_i         (block),
        .hazard_a_i      (hazard_a),
        .hazard_b_i      (hazard_b),
        .slot_a          (slot_a.src),
        .slot_b          (slot_b.src),
        .issue_a_o       (issue_a),
        .issue_b_o       (issue_b),
        .fetch0_accept_o (fetch0_accept_o),
        .fetch1_accept_o (fetch1_accept_o),
        .mispredict_o    (mispredict)
    );

    // --------------------
    // Issue constraints
    // --------------------
    issue_block_fsm u_block_fsm (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .slot_a     (slot_a.sink),
        .issue_a_i  (issue_a),
        .div_done_i (div_done_i),
        .csr_done_i (csr_done_i),
        .block_o    (block)
    );

    issue_scoreboard u_scoreboard (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .slot_a     (slot_a.sink),
        .slot_b     (slot_b.sink),
        .issue_a_i  (issue_a),
        .issue_b_i  (issue_b),
        .wb_valid_i (wb_valid_i),
        .wb_rd_i    (wb_rd_i),
        .hazard_a_o (hazard_a),
        .hazard_b_o (hazard_b)
    );

    // Operands
    issue_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_valid_i (wb_valid_i),
        .wb_rd_i    (wb_rd_i),
        .wb_value_i (wb_value_i),
        .slot_a     (slot_a.sink),
        .slot_b     (slot_b.sink),
        .a_ra_o     (issue0_ra_value_o),
        .a_rb_o     (issue0_rb_value_o),
        .b_ra_o     (issue1_ra_value_o),
        .b_rb_o     (issue1_rb_value_o)
    );

    assign issue0_valid_o  = issue_a;
    assign issue0_opcode_o = slot_a.opcode;
    assign issue0_pc_o     = slot_a.pc;
    assign issue1_valid_o  = issue_b;
    assign issue1_opcode_o = slot_b.opcode;
    assign issue1_pc_o     = slot_b.pc;

    // Fetch restarts from where program order expects it
    assign branch_request_o = mispredict;
    assign branch_pc_o      = expected_pc;

endmodule

`default_nettype wire

//--- tb_issue.sv
// Testbench for the two slot issue stage
// Replays cycle by cycle steps from issue_tests.txt and checks accepts,
// issue valids, operands and branch requests, then runs a load hazard
// case on a randomly chosen register
`timescale 1ns/1ns
`default_nettype none

module tb_issue import issue_pkg::*;;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_STEPS    = 64;
    localparam int NUM_COLS     = 25;
    localparam int HOLD_CYCLES  = 3;

    logic                 clk_i;
    logic                 rst_i;
    logic                 fetch0_valid_i;
    logic [XLEN-1:0]      fetch0_instr_i;
    logic [XLEN-1:0]      fetch0_pc_i;
    logic [2:0]           fetch0_cls_i;
    logic                 fetch1_valid_i;
    logic [XLEN-1:0]      fetch1_instr_i;
    logic [XLEN-1:0]      fetch1_pc_i;
    logic [2:0]           fetch1_cls_i;
    logic                 redirect_valid_i;
    logic [XLEN-1:0]      redirect_pc_i;
    logic                 wb_valid_i;
    logic [REG_IDX_W-1:0] wb_rd_i;
    logic [XLEN-1:0]      wb_value_i;
    logic                 div_done_i;
    logic                 csr_done_i;
    logic                 fetch0_accept_o;
    logic                 fetch1_accept_o;
    logic                 issue0_valid_o;
    logic [XLEN-1:0]      issue0_opcode_o;
    logic [XLEN-1:0]      issue0_pc_o;
    logic [XLEN-1:0]      issue0_ra_value_o;
    logic [XLEN-1:0]      issue0_rb_value_o;
    logic                 issue1_valid_o;
    logic [XLEN-1:0]      issue1_opcode_o;
    logic [XLEN-1:0]      issue1_pc_o;
    logic [XLEN-1:0]      issue1_ra_value_o;
    logic [XLEN-1:0]      issue1_rb_value_o;
    logic                 branch_request_o;
    logic [XLEN-1:0]      branch_pc_o;

    // Columns 0..14 are inputs, 15..24 expected outputs
    string       step_name [MAX_STEPS];
    logic [31:0] step_col  [MAX_STEPS][NUM_COLS];
    int          num_steps;
    bit          tests_loaded;
    int          error_count;
    int          check_count;
    integer      seed;

    issue_top dut0 (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .fetch0_valid_i    (fetch0_valid_i),
        .fetch0_instr_i    (fetch0_instr_i),
        .fetch0_pc_i       (fetch0_pc_i),
        .fetch0_cls_i      (fetch0_cls_i),
        .fetch1_valid_i    (fetch1_valid_i),
        .fetch1_instr_i    (fetch1_instr_i),
        .fetch1_pc_i       (fetch1_pc_i),
        .fetch1_cls_i      (fetch1_cls_i),
        .redirect_valid_i  (redirect_valid_i),
        .redirect_pc_i     (redirect_pc_i),
        .wb_valid_i        (wb_valid_i),
        .wb_rd_i           (wb_rd_i),
        .wb_value_i        (wb_value_i),
        .div_done_i        (div_done_i),
        .csr_done_i        (csr_done_i),
        .fetch0_accept_o   (fetch0_accept_o),
        .fetch1_accept_o   (fetch1_accept_o),
        .issue0_valid_o    (issue0_valid_o),
        .issue0_opcode_o   (issue0_opcode_o),
        .issue0_pc_o       (issue0_pc_o),
        .issue0_ra_value_o (issue0_ra_value_o),
        .issue0_rb_value_o (issue0_rb_value_o),
        .issue1_valid_o    (issue1_valid_o),
        .issue1_opcode_o   (issue1_opcode_o),
        .issue1_pc_o       (issue1_pc_o),
        .issue1_ra_value_o (issue1_ra_value_o),
        .issue1_rb_value_o (issue1_rb_value_o),
        .branch_request_o  (branch_request_o),
        .branch_pc_o       (branch_pc_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_val(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %s %s expected %h actual %h", test, field, expected, actual);
        end
    endtask

    function automatic logic [31:0] encode_instr(input logic [4:0] rd, input logic [4:0] ra,
                                                 input logic [4:0] rb);
        logic [31:0] w;
        w = '0;
        w[RD_LSB +: REG_IDX_W] = rd;
        w[RA_LSB +: REG_IDX_W] = ra;
        w[RB_LSB +: REG_IDX_W] = rb;
        return w;
    endfunction

    task automatic clear_inputs;
        fetch0_valid_i   = 1'b0;
        fetch0_instr_i   = '0;
        fetch0_pc_i      = '0;
        fetch0_cls_i     = '0;
        fetch1_valid_i   = 1'b0;
        fetch1_instr_i   = '0;
        fetch1_pc_i      = '0;
        fetch1_cls_i     = '0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        wb_valid_i       = 1'b0;
        wb_rd_i          = '0;
        wb_value_i       = '0;
        div_done_i       = 1'b0;
        csr_done_i       = 1'b0;
    endtask

    task automatic load_tests;
        integer      fd;
        integer      rc;
        string       tok;
        string       rest;
        logic [31:0] val;
        num_steps = 0;
        fd = $fopen("issue_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open issue_tests.txt for reading");
            error_count++;
        end
        else
        begin
            rc = $fscanf(fd, "%s", tok);
            while (rc == 1 && num_steps < MAX_STEPS)
            begin
                if (tok.substr(0, 0) == "#")
                begin
                    rc = $fgets(rest, fd);
                end
                else
                begin
                    step_name[num_steps] = tok;
                    for (int k = 0; k < NUM_COLS; k++)
                    begin
                        rc = $fscanf(fd, "%h", val);
                        if (rc != 1)
                        begin
                            $display("Test line %s has too few columns", tok);
                            error_count++;
                        end
                        step_col[num_steps][k] = val;
                    end
                    num_steps++;
                end
                rc = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        tests_loaded = 1'b1;
    endtask

    // --------------------
    // Step replay
    // --------------------
    task automatic drive_step(input int i);
        fetch0_valid_i   = step_col[i][0][0];
        fetch0_instr_i   = step_col[i][1];
        fetch0_pc_i      = step_col[i][2];
        fetch0_cls_i     = step_col[i][3][2:0];
        fetch1_valid_i   = step_col[i][4][0];
        fetch1_instr_i   = step_col[i][5];
        fetch1_pc_i      = step_col[i][6];
        fetch1_cls_i     = step_col[i][7][2:0];
        redirect_valid_i = step_col[i][8][0];
        redirect_pc_i    = step_col[i][9];
        wb_valid_i       = step_col[i][10][0];
        wb_rd_i          = step_col[i][11][4:0];
        wb_value_i       = step_col[i][12];
        div_done_i       = step_col[i][13][0];
        csr_done_i       = step_col[i][14][0];
    endtask

    task automatic check_step(input int i);
        string n;
        n = step_name[i];
        check_val(n, "fetch0_accept", step_col[i][15], 32'(fetch0_accept_o));
        check_val(n, "fetch1_accept", step_col[i][16], 32'(fetch1_accept_o));
        check_val(n, "issue0_valid", step_col[i][17], 32'(issue0_valid_o));
        check_val(n, "issue1_valid", step_col[i][18], 32'(issue1_valid_o));
        // Slot A holds word 0 at the expected PC in every issuing step
        if (step_col[i][17][0])
        begin
            check_val(n, "issue0_opcode", step_col[i][1], issue0_opcode_o);
            check_val(n, "issue0_pc", step_col[i][24], issue0_pc_o);
            check_val(n, "issue0_ra", step_col[i][19], issue0_ra_value_o);
            check_val(n, "issue0_rb", step_col[i][20], issue0_rb_value_o);
        end
        if (step_col[i][18][0])
        begin
            check_val(n, "issue1_opcode", step_col[i][5], issue1_opcode_o);
            check_val(n, "issue1_pc", step_col[i][6], issue1_pc_o);
            check_val(n, "issue1_ra", step_col[i][21], issue1_ra_value_o);
            check_val(n, "issue1_rb", step_col[i][22], issue1_rb_value_o);
        end
        check_val(n, "branch_request", step_col[i][23], 32'(branch_request_o));
        check_val(n, "branch_pc", step_col[i][24], branch_pc_o);
    endtask

    // Load to a random register, then a dependent ALU op waits for its writeback
    task automatic run_load_hazard;
        logic [4:0]  idx_set [4];
        logic [4:0]  r;
        logic [31:0] ld_instr;
        logic [31:0] use_instr;
        logic [31:0] wb_val;
        string       n;
        idx_set[0] = 5'd19;
        idx_set[1] = 5'd21;
        idx_set[2] = 5'd25;
        idx_set[3] = 5'd29;
        r         = idx_set[{$random(seed)} % 4];
        n         = $sformatf("load_hazard_r%0d", r);
        wb_val    = 32'h1000 + 32'(r);
        ld_instr  = encode_instr(r, 5'd1, 5'd0);
        use_instr = encode_instr(5'd20, r, 5'd2);

        // Park the expected PC at a known address
        @(posedge clk_i);
        #1;
        clear_inputs();
        redirect_valid_i = 1'b1;
        redirect_pc_i    = 32'h400;

        @(posedge clk_i);
        #1;
        clear_inputs();
        fetch0_valid_i = 1'b1;
        fetch0_instr_i = ld_instr;
        fetch0_pc_i    = 32'h400;
        fetch0_cls_i   = CLS_LOAD;
        #4;
        check_val(n, "load fetch0_accept", 32'd1, 32'(fetch0_accept_o));

        repeat (HOLD_CYCLES)
        begin
            @(posedge clk_i);
            #1;
            fetch0_instr_i = use_instr;
            fetch0_pc_i    = 32'h404;
            fetch0_cls_i   = CLS_ALU;
            #4;
            check_val(n, "stalled fetch0_accept", 32'd0, 32'(fetch0_accept_o));
        end

        @(posedge clk_i);
        #1;
        wb_valid_i = 1'b1;
        wb_rd_i    = r;
        wb_value_i = wb_val;
        #4;
        check_val(n, "release fetch0_accept", 32'd1, 32'(fetch0_accept_o));
        check_val(n, "release issue0_valid", 32'd1, 32'(issue0_valid_o));
        check_val(n, "release issue0_ra", wb_val, issue0_ra_value_o);
        check_val(n, "release issue0_rb", 32'h0b2, issue0_rb_value_o);

        @(posedge clk_i);
        #1;
        clear_inputs();
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        seed         = 32'h6b4d1d31;
        error_count  = 0;
        check_count  = 0;
        tests_loaded = 1'b0;
        clear_inputs();
        rst_i = 1'b1;
        load_tests();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        if (num_steps == 0)
        begin
            $display("No test steps were read, nothing was run");
            error_count++;
        end
        else
        begin
            for (int i = 0; i < num_steps; i++)
            begin
                @(posedge clk_i);
                #1;
                drive_step(i);
                #4;
                check_step(i);
            end
            run_load_hazard();
        end
        error_count += dut0.u_issue_assert.fail_count;
        $display("Run complete with %0d checks, %0d assertion failures and %0d errors",
                 check_count, dut0.u_issue_assert.fail_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Watchdog sized from the number of test steps
    initial
    begin
        wait (tests_loaded);
        #((num_steps + 40) * CLK_PERIOD);
        $display("Timeout after %0d cycles, the run did not complete", num_steps + 40);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_issue_assert.sv
// Protocol assertions on the issue stage top level
// Fetch order, no issue during a redirect, slot 1 only with slot 0
`timescale 1ns/1ns
`default_nettype none

module tb_issue_assert import issue_pkg::*;
(
    input logic            clk_i,
    input logic            rst_i,
    input logic            fetch0_valid_i,
    input logic [XLEN-1:0] fetch0_pc_i,
    input logic            redirect_valid_i,
    input logic            fetch0_accept_o,
    input logic            fetch1_accept_o,
    input logic            issue0_valid_o,
    input logic            issue1_valid_o,
    input logic            branch_request_o,
    input logic [XLEN-1:0] branch_pc_o
);

    int fail_count = 0;

    // Word 1 never overtakes a held word 0 at the expected PC
    a_fetch_order: assert property (@(posedge clk_i) disable iff (rst_i)
        (fetch0_valid_i && (fetch0_pc_i == branch_pc_o) && !fetch0_accept_o)
            |-> !fetch1_accept_o)
    else
    begin
        fail_count++;
        $error("fetch1 accepted while fetch0 at the expected PC was held");
    end

    a_no_issue_redirect: assert property (@(posedge clk_i) disable iff (rst_i)
        (redirect_valid_i || branch_request_o) |-> !(issue0_valid_o || issue1_valid_o))
    else
    begin
        fail_count++;
        $error("issue valid high during a redirect");
    end

    a_slot_order: assert property (@(posedge clk_i) disable iff (rst_i)
        issue1_valid_o |-> issue0_valid_o)
    else
    begin
        fail_count++;
        $error("issue1 valid without issue0 valid");
    end

endmodule

bind issue_top tb_issue_assert u_issue_assert (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .fetch0_valid_i   (fetch0_valid_i),
    .fetch0_pc_i      (fetch0_pc_i),
    .redirect_valid_i (redirect_valid_i),
    .fetch0_accept_o  (fetch0_accept_o),
    .fetch1_accept_o  (fetch1_accept_o),
    .issue0_valid_o   (issue0_valid_o),
    .issue1_valid_o   (issue1_valid_o),
    .branch_request_o (branch_request_o),
    .branch_pc_o      (branch_pc_o)
);

`default_nettype wire
